// File: Bender.yml
package:
  name: soc_bus

export_include_dirs:
  - .

sources:
  - soc_pkg.sv
  - bus_arbiter.sv
  - region_decode.sv
  - block_ram.sv
  - periph_bridge.sv
  - soc_bus.sv
  - target: simulation
    files:
      - soc_bus_assert.sv
      - tb_soc_bus.sv

// File: block_ram.sv
`default_nettype none

`include "soc_macros.svh"

module block_ram (
	input  wire                         i_clock,
	input  wire                         i_req,
	input  wire soc_pkg::bus_req_t      i_bus,
	output soc_pkg::bus_rsp_t           o_rsp
);

	localparam int RAM_AW = $clog2(`SOC_RAM_WORDS);

	soc_pkg::bus_data_t mem [`SOC_RAM_WORDS];
	soc_pkg::bus_data_t rdata_q;
	logic               ready_q;
	logic [RAM_AW-1:0]  index;

	// Word index, wraps inside the region
	assign index = i_bus.addr[RAM_AW+1:2];

	always_ff @(posedge i_clock) begin
		if (i_req && i_bus.rw) begin
			mem[index] <= i_bus.wdata;
		end
		rdata_q <= mem[index];
	end

	// Single pulse even while the request is still held
	always_ff @(posedge i_clock) begin
		ready_q <= i_req && !ready_q;
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: bus_arbiter.sv
`default_nettype none

module bus_arbiter (
	input  wire                         i_clock,
	input  wire                         i_rst,

	// Port A, instruction fetch
	input  wire                         i_a_req,
	input  wire soc_pkg::bus_addr_t     i_a_addr,
	output logic                        o_a_ready,
	output soc_pkg::bus_data_t          o_a_rdata,

	// Port B, data
	input  wire                         i_b_req,
	input  wire soc_pkg::bus_req_t      i_b_bus,
	output logic                        o_b_ready,
	output soc_pkg::bus_data_t          o_b_rdata,

	// Shared bus
	output logic                        o_bus_req,
	output soc_pkg::bus_req_t           o_bus,
	output soc_pkg::port_id_t           o_grant,
	input  wire soc_pkg::bus_rsp_t      i_bus_rsp
);

	soc_pkg::arb_state_t state;
	soc_pkg::port_id_t   served;
	logic                a_take;
	logic                b_take;

	// A port just served is held off for one cycle
	assign a_take = i_a_req && (served != soc_pkg::PORT_A);
	assign b_take = i_b_req && (served != soc_pkg::PORT_B);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state     <= soc_pkg::ARB_IDLE;
			o_bus_req <= 1'b0;
			o_grant   <= soc_pkg::PORT_NONE;
			served    <= soc_pkg::PORT_NONE;
		end else begin
			served <= soc_pkg::PORT_NONE;
			case (state)
				soc_pkg::ARB_IDLE: begin
					// Data port has priority
					if (b_take) begin
						state     <= soc_pkg::ARB_BUSY;
						o_bus_req <= 1'b1;
						o_grant   <= soc_pkg::PORT_B;
					end else if (a_take) begin
						state     <= soc_pkg::ARB_BUSY;
						o_bus_req <= 1'b1;
						o_grant   <= soc_pkg::PORT_A;
					end
				end
				soc_pkg::ARB_BUSY: begin
					if (i_bus_rsp.ready) begin
						state     <= soc_pkg::ARB_IDLE;
						o_bus_req <= 1'b0;
						served    <= o_grant;
						o_grant   <= soc_pkg::PORT_NONE;
					end
				end
				default: state <= soc_pkg::ARB_IDLE;
			endcase
		end
	end

	// Bus payload, loaded only on acceptance
	always_ff @(posedge i_clock) begin
		if (state == soc_pkg::ARB_IDLE) begin
			if (b_take) begin
				o_bus <= i_b_bus;
			end else if (a_take) begin
				o_bus <= '{rw: 1'b0, addr: i_a_addr, wdata: '0};
			end
		end
	end

	// ==========================================================
	// Response routing
	// ==========================================================

	assign o_a_ready = (state == soc_pkg::ARB_BUSY) && (o_grant == soc_pkg::PORT_A)
		&& i_bus_rsp.ready;
	assign o_b_ready = (state == soc_pkg::ARB_BUSY) && (o_grant == soc_pkg::PORT_B)
		&& i_bus_rsp.ready;

	assign o_a_rdata = i_bus_rsp.rdata;
	assign o_b_rdata = i_bus_rsp.rdata;

endmodule

`default_nettype wire

// File: periph_bridge.sv
`default_nettype none

`include "soc_macros.svh"

module periph_bridge (
	input  wire                         i_clock,
	input  wire                         i_rst,
	input  wire                         i_req,
	input  wire soc_pkg::bus_req_t      i_bus,
	output soc_pkg::bus_rsp_t           o_rsp,
	output soc_pkg::led_t               o_led
);

	soc_pkg::bridge_state_t state;
	logic                   ready_q;
	soc_pkg::led_t          led_q;

	// Captured near request
	logic                   rw_q;
	soc_pkg::far_addr_t     far_q;
	soc_pkg::bus_data_t     wdata_q;

	soc_pkg::bus_data_t     rdata_q;
	soc_pkg::bus_data_t     far_rdata;
	logic [`SOC_DEV_W-1:0]  dev;

	assign dev = far_q[`SOC_FAR_W-1 -: `SOC_DEV_W];

	always_comb begin
		far_rdata = '0;
		if (!rw_q) begin
			case (dev)
				`SOC_DEV_LED: far_rdata = soc_pkg::bus_data_t'(led_q);
				`SOC_DEV_ID:  far_rdata = `SOC_SYS_ID;
				default:      far_rdata = '0;
			endcase
		end
	end

	// ==========================================================
	// Capture, access, return
	// ==========================================================

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state   <= soc_pkg::BR_IDLE;
			ready_q <= 1'b0;
			led_q   <= '0;
		end else begin
			ready_q <= 1'b0;
			case (state)
				soc_pkg::BR_IDLE: begin
					// Held request after ready is not a new access
					if (i_req && !ready_q) begin
						state <= soc_pkg::BR_ACCESS;
					end
				end
				soc_pkg::BR_ACCESS: begin
					if (rw_q && (dev == `SOC_DEV_LED)) begin
						led_q <= wdata_q[`SOC_LED_W-1:0];
					end
					state <= soc_pkg::BR_DONE;
				end
				soc_pkg::BR_DONE: begin
					ready_q <= 1'b1;
					state   <= soc_pkg::BR_IDLE;
				end
				default: state <= soc_pkg::BR_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == soc_pkg::BR_IDLE) begin
			rw_q    <= i_bus.rw;
			far_q   <= i_bus.addr[`SOC_FAR_W-1:0];
			wdata_q <= i_bus.wdata;
		end
		if (state == soc_pkg::BR_ACCESS) begin
			rdata_q <= far_rdata;
		end
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};
	assign o_led = led_q;

endmodule

`default_nettype wire

// File: region_decode.sv
`default_nettype none

`include "soc_macros.svh"

module region_decode (
	input  wire                         i_clock,
	input  wire                         i_rst,
	input  wire                         i_bus_req,
	input  wire soc_pkg::bus_req_t      i_bus,
	input  wire soc_pkg::port_id_t      i_grant,
	output soc_pkg::bus_rsp_t           o_bus_rsp,
	output logic                        o_ram_req,
	input  wire soc_pkg::bus_rsp_t      i_ram_rsp,
	output logic                        o_br_req,
	input  wire soc_pkg::bus_rsp_t      i_br_rsp,
	output logic                        o_fault,
	output soc_pkg::bus_addr_t          o_fault_addr,
	output soc_pkg::port_id_t           o_fault_port
);

	soc_pkg::region_t region;
	logic             ram_sel;
	logic             br_sel;
	logic             unmapped;
	logic             unm_ready;

	assign region   = i_bus.addr[`SOC_ADDR_W-1 -: `SOC_REGION_W];
	assign ram_sel  = (region == `SOC_REGION_RAM);
	assign br_sel   = (region == `SOC_REGION_BRIDGE);
	assign unmapped = !ram_sel && !br_sel;

	assign o_ram_req = i_bus_req && ram_sel;
	assign o_br_req  = i_bus_req && br_sel;

	// Unmapped accesses still complete, one cycle late
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			unm_ready <= 1'b0;
		end else begin
			unm_ready <= i_bus_req && unmapped && !unm_ready;
		end
	end

	always_comb begin
		if (ram_sel) begin
			o_bus_rsp = i_ram_rsp;
		end else if (br_sel) begin
			o_bus_rsp = i_br_rsp;
		end else begin
			o_bus_rsp = '{ready: unm_ready, rdata: '0};
		end
	end

	// ==========================================================
	// Fault capture
	// ==========================================================

	// Sticky, keeps the first faulting access
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_fault      <= 1'b0;
			o_fault_addr <= '0;
			o_fault_port <= soc_pkg::PORT_NONE;
		end else if (i_bus_req && unmapped && !o_fault) begin
			o_fault      <= 1'b1;
			o_fault_addr <= i_bus.addr;
			o_fault_port <= i_grant;
		end
	end

endmodule

`default_nettype wire

// File: soc_bus.sv
`default_nettype none

module soc_bus (
	input  wire                         i_clock,
	input  wire                         i_rst,

	input  wire                         i_a_req,
	input  wire soc_pkg::bus_addr_t     i_a_addr,
	output soc_pkg::bus_data_t          o_a_rdata,
	output logic                        o_a_ready,

	input  wire                         i_b_req,
	input  wire soc_pkg::bus_req_t      i_b_bus,
	output soc_pkg::bus_data_t          o_b_rdata,
	output logic                        o_b_ready,

	output soc_pkg::led_t               o_led,
	output logic                        o_fault,
	output soc_pkg::bus_addr_t          o_fault_addr,
	output soc_pkg::port_id_t           o_fault_port
);

	logic               bus_request;
	soc_pkg::bus_req_t  bus;
	soc_pkg::port_id_t  grant;
	soc_pkg::bus_rsp_t  bus_rsp;

	logic               ram_req;
	soc_pkg::bus_rsp_t  ram_rsp;
	logic               br_req;
	soc_pkg::bus_rsp_t  br_rsp;

	bus_arbiter arbiter (
		.i_clock   (i_clock),
		.i_rst     (i_rst),
		.i_a_req   (i_a_req),
		.i_a_addr  (i_a_addr),
		.o_a_ready (o_a_ready),
		.o_a_rdata (o_a_rdata),
		.i_b_req   (i_b_req),
		.i_b_bus   (i_b_bus),
		.o_b_ready (o_b_ready),
		.o_b_rdata (o_b_rdata),
		.o_bus_req (bus_request),
		.o_bus     (bus),
		.o_grant   (grant),
		.i_bus_rsp (bus_rsp)
	);

	region_decode decode (
		.i_clock      (i_clock),
		.i_rst        (i_rst),
		.i_bus_req    (bus_request),
		.i_bus        (bus),
		.i_grant      (grant),
		.o_bus_rsp    (bus_rsp),
		.o_ram_req    (ram_req),
		.i_ram_rsp    (ram_rsp),
		.o_br_req     (br_req),
		.i_br_rsp     (br_rsp),
		.o_fault      (o_fault),
		.o_fault_addr (o_fault_addr),
		.o_fault_port (o_fault_port)
	);

	// ==========================================================
	// Targets
	// ==========================================================

	block_ram ram (
		.i_clock (i_clock),
		.i_req   (ram_req),
		.i_bus   (bus),
		.o_rsp   (ram_rsp)
	);

	periph_bridge bridge (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_req   (br_req),
		.i_bus   (bus),
		.o_rsp   (br_rsp),
		.o_led   (o_led)
	);

endmodule

`default_nettype wire

// File: soc_bus_assert.sv
`default_nettype none

module soc_bus_assert (
	input wire                    i_clock,
	input wire                    i_rst,
	input wire                    i_a_req,
	input wire                    i_b_req,
	input wire                    i_a_ready,
	input wire                    i_b_ready,
	input wire                    i_bus_req,
	input wire soc_pkg::bus_req_t i_bus,
	input wire soc_pkg::port_id_t i_grant,
	input wire soc_pkg::bus_rsp_t i_bus_rsp
);

	int fail_count = 0;

	// One ready at a time, and only to a port that is requesting
	ready_exclusive: assert property (@(posedge i_clock) disable iff (i_rst)
		!(i_a_ready && i_b_ready) && (!i_a_ready || i_a_req) && (!i_b_ready || i_b_req))
	else begin
		fail_count++;
		$error("Port ready overlapped the other port or reached an idle port");
	end

	a_ready_pulse: assert property (@(posedge i_clock) disable iff (i_rst)
		i_a_ready |=> !i_a_ready)
	else begin
		fail_count++;
		$error("Port A ready held longer than one cycle");
	end

	b_ready_pulse: assert property (@(posedge i_clock) disable iff (i_rst)
		i_b_ready |=> !i_b_ready)
	else begin
		fail_count++;
		$error("Port B ready held longer than one cycle");
	end

	// Shared bus holds until the target answers
	bus_stable: assert property (@(posedge i_clock) disable iff (i_rst)
		(i_bus_req && !i_bus_rsp.ready) |=> (i_bus_req && $stable(i_bus) && $stable(i_grant)))
	else begin
		fail_count++;
		$error("Shared bus request changed before ready");
	end

endmodule

bind bus_arbiter soc_bus_assert chk (
	.i_clock   (i_clock),
	.i_rst     (i_rst),
	.i_a_req   (i_a_req),
	.i_b_req   (i_b_req),
	.i_a_ready (o_a_ready),
	.i_b_ready (o_b_ready),
	.i_bus_req (o_bus_req),
	.i_bus     (o_bus),
	.i_grant   (o_grant),
	.i_bus_rsp (i_bus_rsp)
);

`default_nettype wire

// File: soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_REGION_W 4
`define SOC_FAR_W 28
`define SOC_DEV_W 4

// Regions from address bits 31:28
`define SOC_REGION_RAM 4'h1
`define SOC_REGION_BRIDGE 4'h5

// Devices behind the bridge, far address bits 27:24
`define SOC_DEV_LED 4'h0
`define SOC_DEV_ID 4'h1

`define SOC_RAM_WORDS 512
`define SOC_LED_W 10
`define SOC_SYS_ID 32'h5C0B_0001

`endif

// File: soc_pkg.sv
`default_nettype none

`include "soc_macros.svh"

package soc_pkg;

	typedef logic [`SOC_ADDR_W-1:0] bus_addr_t;
	typedef logic [`SOC_DATA_W-1:0] bus_data_t;
	typedef logic [`SOC_REGION_W-1:0] region_t;
	typedef logic [`SOC_FAR_W-1:0] far_addr_t;
	typedef logic [`SOC_LED_W-1:0] led_t;

	// Requesting port, also the fault port code
	typedef enum logic [1:0] {
		PORT_NONE = 2'd0,
		PORT_A    = 2'd1,
		PORT_B    = 2'd2
	} port_id_t;

	// rw is high for a write
	typedef struct packed {
		logic      rw;
		bus_addr_t addr;
		bus_data_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic      ready;
		bus_data_t rdata;
	} bus_rsp_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_t;

	typedef enum logic [1:0] {
		BR_IDLE,
		BR_ACCESS,
		BR_DONE
	} bridge_state_t;

endpackage

`default_nettype wire

// File: tb_soc_bus.sv
`default_nettype none

`include "soc_macros.svh"

module tb_soc_bus;

	localparam int RAM_TXN     = 16;
	localparam int MIX_ROUNDS  = 24;
	localparam int NUM_TXN     = 3 * RAM_TXN + 2 * MIX_ROUNDS + 15;
	localparam int CYCLE_LIMIT = NUM_TXN * 10 + 200;

	logic               i_clock;
	logic               i_rst;
	logic               i_a_req;
	soc_pkg::bus_addr_t i_a_addr;
	soc_pkg::bus_data_t o_a_rdata;
	logic               o_a_ready;
	logic               i_b_req;
	soc_pkg::bus_req_t  i_b_bus;
	soc_pkg::bus_data_t o_b_rdata;
	logic               o_b_ready;
	soc_pkg::led_t      o_led;
	logic               o_fault;
	soc_pkg::bus_addr_t o_fault_addr;
	soc_pkg::port_id_t  o_fault_port;

	// Reference model state
	soc_pkg::bus_data_t ref_ram [`SOC_RAM_WORDS];
	soc_pkg::led_t      ref_led;
	logic               ref_fault;
	soc_pkg::bus_addr_t ref_fault_addr;
	soc_pkg::port_id_t  ref_fault_port;

	// Request in flight on each port
	soc_pkg::bus_req_t  a_cur;
	soc_pkg::bus_req_t  b_cur;
	logic               a_pending;
	logic               b_pending;
	int                 errors;
	int                 checks;
	int                 issued;
	int                 completed;
	int                 cycles;
	soc_pkg::bus_addr_t written_q [$];

	soc_bus uut (.*);

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge i_clock);
			cycles++;
		end
		$display("Timeout after %0d cycles, a request never completed", cycles);
		$display("Errors found");
		$finish;
	end

	// Expected read data, and the model update for the access
	function automatic soc_pkg::bus_data_t ref_access(input soc_pkg::port_id_t port,
		input soc_pkg::bus_req_t req);
		soc_pkg::bus_data_t data;
		logic [3:0]         region;
		logic [3:0]         dev;
		int                 idx;
		data   = '0;
		region = req.addr[31:28];
		dev    = req.addr[27:24];
		idx    = int'(req.addr[10:2]);
		if (region == `SOC_REGION_RAM) begin
			if (req.rw) ref_ram[idx] = req.wdata;
			else data = ref_ram[idx];
		end else if (region == `SOC_REGION_BRIDGE) begin
			if (req.rw && dev == `SOC_DEV_LED) ref_led = req.wdata[`SOC_LED_W-1:0];
			else if (!req.rw && dev == `SOC_DEV_LED) data[`SOC_LED_W-1:0] = ref_led;
			else if (!req.rw && dev == `SOC_DEV_ID) data = `SOC_SYS_ID;
		end else if (!ref_fault) begin
			// First unmapped access is the one kept
			ref_fault      = 1'b1;
			ref_fault_addr = req.addr;
			ref_fault_port = port;
		end
		return data;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_outputs();
		check_eq("o_led", o_led, ref_led);
		check_eq("o_fault", o_fault, ref_fault);
		check_eq("o_fault_addr", o_fault_addr, ref_fault_addr);
		check_eq("o_fault_port", o_fault_port, ref_fault_port);
	endtask

	// ============================================================
	// Response checking
	// ============================================================

	always @(posedge i_clock) begin
		soc_pkg::bus_data_t exp;
		if (o_a_ready) begin
			assert (a_pending) else begin
				errors++;
				$display("Port A got a ready at %0t with no request pending", $time);
			end
			exp = ref_access(soc_pkg::PORT_A, a_cur);
			check_eq("o_a_rdata", o_a_rdata, exp);
			check_outputs();
			a_pending = 1'b0;
			completed++;
		end
		if (o_b_ready) begin
			assert (b_pending) else begin
				errors++;
				$display("Port B got a ready at %0t with no request pending", $time);
			end
			exp = ref_access(soc_pkg::PORT_B, b_cur);
			if (!b_cur.rw) check_eq("o_b_rdata", o_b_rdata, exp);
			check_outputs();
			b_pending = 1'b0;
			completed++;
		end
	end

	task automatic issue_a(input soc_pkg::bus_addr_t addr);
		@(posedge i_clock);
		i_a_req   <= 1'b1;
		i_a_addr  <= addr;
		a_cur      = '{rw: 1'b0, addr: addr, wdata: '0};
		a_pending  = 1'b1;
		issued++;
		do @(posedge i_clock); while (!o_a_ready);
		i_a_req <= 1'b0;
		@(posedge i_clock);
	endtask

	task automatic issue_b(input soc_pkg::bus_req_t req);
		@(posedge i_clock);
		i_b_req   <= 1'b1;
		i_b_bus   <= req;
		b_cur      = req;
		b_pending  = 1'b1;
		issued++;
		do @(posedge i_clock); while (!o_b_ready);
		i_b_req <= 1'b0;
		@(posedge i_clock);
	endtask

	task automatic report_test(input string name, input int mark);
		$display("Test %-22s done, %0d errors", name, errors - mark);
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		soc_pkg::bus_addr_t addr;
		soc_pkg::bus_addr_t a_addr;
		soc_pkg::bus_req_t  b_req;
		soc_pkg::bus_data_t data;
		int                 a_delay;
		int                 b_delay;
		int                 mark;
		int                 r;
		int                 total;
		void'($urandom(32'hbae9d247));
		i_rst = 1'b1;
		i_a_req = 1'b0;
		i_a_addr = '0;
		i_b_req = 1'b0;
		i_b_bus = '0;
		{errors, checks, issued, completed} = '0;
		{a_pending, b_pending, ref_fault} = '0;
		ref_led = '0;
		ref_fault_addr = '0;
		ref_fault_port = soc_pkg::PORT_NONE;
		repeat (2) @(posedge i_clock);
		i_rst <= 1'b0;
		@(posedge i_clock);

		mark = errors;
		check_outputs();
		check_eq("o_a_ready", o_a_ready, 0);
		check_eq("o_b_ready", o_b_ready, 0);
		report_test("reset values", mark);

		// Random word addresses, high far bits alias inside the region
		mark = errors;
		for (int i = 0; i < RAM_TXN; i++) begin
			r = $urandom();
			addr = {`SOC_REGION_RAM, r[27:2], 2'b00};
			written_q.push_back(addr);
			issue_b('{rw: 1'b1, addr: addr, wdata: $urandom()});
		end
		foreach (written_q[i]) begin
			issue_b('{rw: 1'b0, addr: written_q[i], wdata: '0});
			issue_a(written_q[i]);
		end
		report_test("ram write and readback", mark);

		mark = errors;
		for (int i = 0; i < MIX_ROUNDS; i++) begin
			a_addr = written_q[$urandom_range(0, written_q.size() - 1)];
			b_req.addr = written_q[$urandom_range(0, written_q.size() - 1)];
			b_req.rw = $urandom_range(0, 1);
			b_req.wdata = $urandom();
			a_delay = $urandom_range(0, 2);
			b_delay = $urandom_range(0, 2);
			fork
				begin
					repeat (a_delay) @(posedge i_clock);
					issue_a(a_addr);
				end
				begin
					repeat (b_delay) @(posedge i_clock);
					issue_b(b_req);
				end
			join
		end
		report_test("concurrent ports", mark);

		mark = errors;
		addr = {`SOC_REGION_BRIDGE, `SOC_DEV_LED, 24'h0};
		for (int i = 0; i < 3; i++) begin
			data = $urandom();
			issue_b('{rw: 1'b1, addr: addr, wdata: data});
			check_eq("o_led", o_led, data[`SOC_LED_W-1:0]);
			issue_b('{rw: 1'b0, addr: addr, wdata: '0});
		end
		issue_a(addr);
		report_test("led register", mark);

		mark = errors;
		addr = {`SOC_REGION_BRIDGE, `SOC_DEV_ID, 24'h0};
		issue_a(addr);
		issue_b('{rw: 1'b0, addr: addr, wdata: '0});
		issue_b('{rw: 1'b1, addr: addr, wdata: $urandom()});
		issue_a(addr);
		report_test("system id", mark);

		mark = errors;
		addr = 32'h3000_0104;
		issue_b('{rw: 1'b0, addr: addr, wdata: '0});
		issue_a(32'h7000_0020);
		issue_b('{rw: 1'b1, addr: 32'hF000_0008, wdata: $urandom()});
		issue_a(32'h0000_0000);
		check_eq("o_fault_addr", o_fault_addr, addr);
		check_eq("o_fault_port", o_fault_port, soc_pkg::PORT_B);
		report_test("unmapped access", mark);

		check_eq("completed requests", completed, issued);
		total = errors + uut.arbiter.chk.fail_count;
		$display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
			uut.arbiter.chk.fail_count);
		if (total == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
soc_pkg.sv
bus_arbiter.sv
region_decode.sv
block_ram.sv
periph_bridge.sv
soc_bus.sv
soc_bus_assert.sv
tb_soc_bus.sv
